/* rtl/ulpb_pkg.sv */
package ulpb_pkg;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int MSG_WIDTH = ADDR_WIDTH + DATA_WIDTH;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int NODE_COUNT = 3;
	localparam int NODE_IDX_WIDTH = $clog2(NODE_COUNT);

	// start bit, message, ack slot
	localparam int FRAME_BITS = 1 + MSG_WIDTH + 1;
	localparam int SLOT_CYCLES = 48;
	localparam int SLOT_CNT_WIDTH = $clog2(SLOT_CYCLES);
	localparam int RX_CNT_WIDTH = $clog2(MSG_WIDTH);

	// slot count at which the ack slot comes back around the ring
	localparam int ACK_RETURN_CNT = FRAME_BITS + NODE_COUNT;

	// per-node address and match mask, index is the node id
	localparam logic [NODE_COUNT-1:0][ADDR_WIDTH-1:0] NODE_ADDR = {8'h30, 8'h20, 8'h10};
	localparam logic [NODE_COUNT-1:0][ADDR_WIDTH-1:0] NODE_MASK = {8'hf0, 8'hff, 8'hff};

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} ulpb_msg_t;

	typedef enum logic [1:0] {
		TX_WAIT,
		TX_SEND,
		TX_RETURN,
		TX_RESULT
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_SHIFT,
		RX_ACK,
		RX_HOLD
	} rx_state_e;

endpackage

/* rtl/ulpb_tx_fifo.sv */
`timescale 1ns/1ps

module ulpb_tx_fifo import ulpb_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic lc_req_in,
	input ulpb_msg_t lc_msg_in,
	output logic lc_ack_out,
	input logic pop,
	output ulpb_msg_t head_msg,
	output logic empty
);

	// pointers carry one extra wrap bit to tell full from empty
	logic [FIFO_PTR_WIDTH:0] head;
	logic [FIFO_PTR_WIDTH:0] tail;
	ulpb_msg_t mem [FIFO_DEPTH];
	logic full;
	logic write;

	assign empty = (head == tail);
	assign full = (head[FIFO_PTR_WIDTH] != tail[FIFO_PTR_WIDTH]) &&
		(head[FIFO_PTR_WIDTH-1:0] == tail[FIFO_PTR_WIDTH-1:0]);

	// a new request is one seen high while ack is still low
	assign write = lc_req_in && !lc_ack_out && !full;

	assign head_msg = mem[head[FIFO_PTR_WIDTH-1:0]];

	always_ff @(posedge CLK)
	begin
		if (write)
			mem[tail[FIFO_PTR_WIDTH-1:0]] <= lc_msg_in;
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			head <= '0;
			tail <= '0;
			lc_ack_out <= 1'b0;
		end
		else
		begin
			if (write)
			begin
				tail <= tail + 1'b1;
				lc_ack_out <= 1'b1;
			end
			else if (lc_ack_out && !lc_req_in)
				lc_ack_out <= 1'b0;
			if (pop)
				head <= head + 1'b1;
		end
	end

endmodule

/* rtl/ulpb_tx_engine.sv */
`timescale 1ns/1ps

module ulpb_tx_engine import ulpb_pkg::*;
#(
	parameter int NODE_ID = 0
)
(
	input logic CLK,
	input logic RESET,
	input ulpb_msg_t head_msg,
	input logic empty,
	output logic pop,
	input logic din,
	output logic tx_bit,
	output logic own_slot,
	output logic tx_success,
	output logic tx_fail,
	input logic tx_ack
);

	tx_state_e state;
	logic [SLOT_CNT_WIDTH-1:0] slot_cnt;
	logic [NODE_IDX_WIDTH-1:0] slot_idx;
	logic [FRAME_BITS-1:0] tx_shift;
	logic slot_start;

	// every node runs the same counters from reset, so slots line up ring-wide
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			slot_cnt <= '0;
			slot_idx <= '0;
		end
		else if (slot_cnt == SLOT_CNT_WIDTH'(SLOT_CYCLES - 1))
		begin
			slot_cnt <= '0;
			if (slot_idx == NODE_IDX_WIDTH'(NODE_COUNT - 1))
				slot_idx <= '0;
			else
				slot_idx <= slot_idx + 1'b1;
		end
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	assign own_slot = (slot_idx == NODE_IDX_WIDTH'(NODE_ID));
	assign slot_start = own_slot && (slot_cnt == '0);

	// a held result keeps the FSM out of TX_WAIT, which blocks a new frame
	assign pop = (state == TX_WAIT) && slot_start && !empty;

	// idle ones outside a frame
	assign tx_bit = (state == TX_SEND) ? tx_shift[FRAME_BITS-1] : 1'b1;

	always_ff @(posedge CLK)
	begin
		if (pop)
			tx_shift <= {1'b0, head_msg, 1'b0};
		else if (state == TX_SEND)
			tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b1};
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= TX_WAIT;
			tx_success <= 1'b0;
			tx_fail <= 1'b0;
		end
		else
		begin
			case (state)
				TX_WAIT:
				begin
					if (pop)
						state <= TX_SEND;
				end
				TX_SEND:
				begin
					// the ack slot is on tx_bit at this count
					if (slot_cnt == SLOT_CNT_WIDTH'(FRAME_BITS))
						state <= TX_RETURN;
				end
				TX_RETURN:
				begin
					// data bits coming back are ignored, only the ack slot counts
					if (slot_cnt == SLOT_CNT_WIDTH'(ACK_RETURN_CNT))
					begin
						tx_success <= din;
						tx_fail <= !din;
						state <= TX_RESULT;
					end
				end
				TX_RESULT:
				begin
					if (tx_ack)
					begin
						tx_success <= 1'b0;
						tx_fail <= 1'b0;
						state <= TX_WAIT;
					end
				end
				default:
					state <= TX_WAIT;
			endcase
		end
	end

endmodule

/* rtl/ulpb_rx_engine.sv */
`timescale 1ns/1ps

module ulpb_rx_engine import ulpb_pkg::*;
#(
	parameter logic [ADDR_WIDTH-1:0] ADDRESS = '0,
	parameter logic [ADDR_WIDTH-1:0] ADDRESS_MASK = '1
)
(
	input logic CLK,
	input logic RESET,
	input logic din,
	input logic listen,
	output logic ack_insert,
	output logic lc_req_out,
	output ulpb_msg_t lc_msg_out,
	input logic lc_ack_in
);

	rx_state_e state;
	logic [RX_CNT_WIDTH-1:0] bit_cnt;
	ulpb_msg_t rx_shift;
	logic buf_full;
	logic addr_hit;

	// only bits set in the mask take part in the compare
	assign addr_hit = ((rx_shift.addr ^ ADDRESS) & ADDRESS_MASK) == '0;

	// din carries the ack slot while in RX_ACK
	assign ack_insert = (state == RX_ACK) && listen && addr_hit && !buf_full;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= RX_IDLE;
			bit_cnt <= '0;
		end
		else if (!listen)
			state <= RX_IDLE;
		else
		begin
			case (state)
				RX_IDLE:
				begin
					if (!din)
					begin
						state <= RX_SHIFT;
						bit_cnt <= '0;
					end
				end
				RX_SHIFT:
				begin
					if (bit_cnt == RX_CNT_WIDTH'(MSG_WIDTH - 1))
						state <= RX_ACK;
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				RX_ACK:
					state <= RX_HOLD;
				// stay off the line until it is back at idle high
				RX_HOLD:
				begin
					if (din)
						state <= RX_IDLE;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == RX_SHIFT)
			rx_shift <= ulpb_msg_t'({rx_shift[MSG_WIDTH-2:0], din});
		if (ack_insert)
			lc_msg_out <= rx_shift;
	end

	// buffer is released only once both sides of the handshake are low
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			lc_req_out <= 1'b0;
			buf_full <= 1'b0;
		end
		else if (ack_insert)
		begin
			lc_req_out <= 1'b1;
			buf_full <= 1'b1;
		end
		else
		begin
			if (lc_req_out && lc_ack_in)
				lc_req_out <= 1'b0;
			if (buf_full && !lc_req_out && !lc_ack_in)
				buf_full <= 1'b0;
		end
	end

endmodule

/* rtl/ulpb_node.sv */
`timescale 1ns/1ps

module ulpb_node import ulpb_pkg::*;
#(
	parameter int NODE_ID = 0,
	parameter logic [ADDR_WIDTH-1:0] ADDRESS = '0,
	parameter logic [ADDR_WIDTH-1:0] ADDRESS_MASK = '1
)
(
	input logic CLK,
	input logic RESET,
	input logic din,
	output logic dout,
	input logic lc_req_in,
	input ulpb_msg_t lc_msg_in,
	output logic lc_ack_out,
	output logic lc_req_out,
	output ulpb_msg_t lc_msg_out,
	input logic lc_ack_in,
	output logic tx_success,
	output logic tx_fail,
	input logic tx_ack
);

	ulpb_msg_t head_msg;
	logic empty;
	logic pop;
	logic tx_bit;
	logic own_slot;
	logic listen;
	logic ack_insert;

	assign listen = ~own_slot;

	// one register per hop, the ring idles high
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			dout <= 1'b1;
		else if (own_slot)
			dout <= tx_bit;
		else
			dout <= din | ack_insert;
	end

	ulpb_tx_fifo u_fifo (
		.CLK(CLK),
		.RESET(RESET),
		.lc_req_in(lc_req_in),
		.lc_msg_in(lc_msg_in),
		.lc_ack_out(lc_ack_out),
		.pop(pop),
		.head_msg(head_msg),
		.empty(empty)
	);

	ulpb_tx_engine #(.NODE_ID(NODE_ID)) u_tx (
		.CLK(CLK),
		.RESET(RESET),
		.head_msg(head_msg),
		.empty(empty),
		.pop(pop),
		.din(din),
		.tx_bit(tx_bit),
		.own_slot(own_slot),
		.tx_success(tx_success),
		.tx_fail(tx_fail),
		.tx_ack(tx_ack)
	);

	ulpb_rx_engine #(.ADDRESS(ADDRESS), .ADDRESS_MASK(ADDRESS_MASK)) u_rx (
		.CLK(CLK),
		.RESET(RESET),
		.din(din),
		.listen(listen),
		.ack_insert(ack_insert),
		.lc_req_out(lc_req_out),
		.lc_msg_out(lc_msg_out),
		.lc_ack_in(lc_ack_in)
	);

endmodule

/* rtl/ulpb_ring_top.sv */
`timescale 1ns/1ps

module ulpb_ring_top import ulpb_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic [NODE_COUNT-1:0] lc_req_in,
	input ulpb_msg_t [NODE_COUNT-1:0] lc_msg_in,
	output logic [NODE_COUNT-1:0] lc_ack_out,
	output logic [NODE_COUNT-1:0] lc_req_out,
	output ulpb_msg_t [NODE_COUNT-1:0] lc_msg_out,
	input logic [NODE_COUNT-1:0] lc_ack_in,
	output logic [NODE_COUNT-1:0] tx_success,
	output logic [NODE_COUNT-1:0] tx_fail,
	input logic [NODE_COUNT-1:0] tx_ack
);

	// ring[k] is the output of node k
	logic [NODE_COUNT-1:0] ring;

	genvar k;
	for (k = 0; k < NODE_COUNT; k++)
	begin : g_node
		ulpb_node #(
			.NODE_ID(k),
			.ADDRESS(NODE_ADDR[k]),
			.ADDRESS_MASK(NODE_MASK[k])
		) u_node (
			.CLK(CLK),
			.RESET(RESET),
			.din(ring[(k + NODE_COUNT - 1) % NODE_COUNT]),
			.dout(ring[k]),
			.lc_req_in(lc_req_in[k]),
			.lc_msg_in(lc_msg_in[k]),
			.lc_ack_out(lc_ack_out[k]),
			.lc_req_out(lc_req_out[k]),
			.lc_msg_out(lc_msg_out[k]),
			.lc_ack_in(lc_ack_in[k]),
			.tx_success(tx_success[k]),
			.tx_fail(tx_fail[k]),
			.tx_ack(tx_ack[k])
		);
	end

endmodule

/* dv/ulpb_ring_sva.sv */
`timescale 1ns/1ps

module ulpb_ring_sva import ulpb_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic dout,
	input logic lc_req_in,
	input logic lc_ack_out,
	input logic lc_req_out,
	input ulpb_msg_t lc_msg_out,
	input logic tx_success,
	input logic tx_fail
);

	result_onehot: assert property (@(posedge CLK) disable iff (!RESET)
		!(tx_success && tx_fail))
		else $error("tx_success and tx_fail are high together");

	// the write ack may only drop once the request has been seen low
	write_ack_release: assert property (@(posedge CLK) disable iff (!RESET)
		$fell(lc_ack_out) |-> !$past(lc_req_in))
		else $error("lc_ack_out fell while lc_req_in was still high");

	read_msg_stable: assert property (@(posedge CLK) disable iff (!RESET)
		(lc_req_out && $past(lc_req_out)) |-> $stable(lc_msg_out))
		else $error("lc_msg_out changed while lc_req_out was high");

	// ring must come out of reset idling high
	idle_after_reset_next: assert property (@(posedge CLK)
		$rose(RESET) |=> dout)
		else $error("dout is low one cycle after reset");

endmodule

bind ulpb_node ulpb_ring_sva u_sva (.*);

/* dv/ulpb_ring_tb.sv */
`timescale 1ns/1ps

module ulpb_ring_tb import ulpb_pkg::*;
();

	typedef struct packed {
		logic [1:0] src;
		logic [ADDR_WIDTH-1:0] addr;
		logic stall;
		logic [1:0] dest;
		logic sync;
	} stim_t;

	localparam int SEED = 99858;
	localparam logic [1:0] NO_NODE = 2'd3;
	localparam int NUM_STIM = 21;
	localparam int STALL_CYCLES = 2 * NODE_COUNT * SLOT_CYCLES;
	localparam int WATCHDOG_CYCLES = NUM_STIM * NODE_COUNT * SLOT_CYCLES * 3;

	// src, addr, receiver stalls, expected receiver, drain before the next entry
	localparam stim_t STIM [NUM_STIM] = '{
		'{2'd0, 8'h20, 1'b0, 2'd1, 1'b1},
		'{2'd0, 8'h30, 1'b0, 2'd2, 1'b1},
		'{2'd1, 8'h10, 1'b0, 2'd0, 1'b1},
		'{2'd1, 8'h30, 1'b0, 2'd2, 1'b1},
		'{2'd2, 8'h10, 1'b0, 2'd0, 1'b1},
		'{2'd2, 8'h20, 1'b0, 2'd1, 1'b1},
		// node 2 matches on the upper nibble only
		'{2'd0, 8'h3f, 1'b0, 2'd2, 1'b1},
		'{2'd1, 8'h35, 1'b0, 2'd2, 1'b1},
		'{2'd1, 8'h3a, 1'b0, 2'd2, 1'b1},
		'{2'd0, 8'h21, 1'b0, NO_NODE, 1'b1},
		// six back to back overflow the four-entry queue
		'{2'd1, 8'h31, 1'b0, 2'd2, 1'b0},
		'{2'd1, 8'h32, 1'b0, 2'd2, 1'b0},
		'{2'd1, 8'h33, 1'b0, 2'd2, 1'b0},
		'{2'd1, 8'h34, 1'b0, 2'd2, 1'b0},
		'{2'd1, 8'h35, 1'b0, 2'd2, 1'b0},
		'{2'd1, 8'h36, 1'b0, 2'd2, 1'b1},
		// second frame finds node 1 still holding the first one
		'{2'd0, 8'h20, 1'b1, 2'd1, 1'b0},
		'{2'd0, 8'h20, 1'b0, NO_NODE, 1'b1},
		'{2'd0, 8'h20, 1'b0, 2'd1, 1'b0},
		'{2'd1, 8'h3c, 1'b0, 2'd2, 1'b0},
		'{2'd2, 8'h10, 1'b0, 2'd0, 1'b1}
	};

	logic CLK = 1'b0;
	logic RESET;
	logic [NODE_COUNT-1:0] lc_req_in;
	ulpb_msg_t [NODE_COUNT-1:0] lc_msg_in;
	logic [NODE_COUNT-1:0] lc_ack_out;
	logic [NODE_COUNT-1:0] lc_req_out;
	ulpb_msg_t [NODE_COUNT-1:0] lc_msg_out;
	logic [NODE_COUNT-1:0] lc_ack_in;
	logic [NODE_COUNT-1:0] tx_success;
	logic [NODE_COUNT-1:0] tx_fail;
	logic [NODE_COUNT-1:0] tx_ack;

	ulpb_msg_t wr_q [NODE_COUNT][$];
	ulpb_msg_t exp_rx [NODE_COUNT][$];
	logic exp_stall [NODE_COUNT][$];
	logic exp_res [NODE_COUNT][$];
	int outstanding = 0;
	int write_stalls = 0;
	int errors = 0;
	int checks = 0;

	ulpb_ring_top dut (.*);

	always #50 CLK = ~CLK;

	task automatic check_msg(input string name, input ulpb_msg_t got, input ulpb_msg_t want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic queue_entry(input stim_t st);
		ulpb_msg_t msg;
		msg.addr = st.addr;
		msg.data = $urandom();
		wr_q[st.src].push_back(msg);
		exp_res[st.src].push_back(st.dest != NO_NODE);
		outstanding++;
		if (st.dest != NO_NODE)
		begin
			exp_rx[st.dest].push_back(msg);
			exp_stall[st.dest].push_back(st.stall);
			outstanding++;
		end
	endtask

	task automatic wait_drain();
		while (outstanding != 0)
			@(posedge CLK);
	endtask

	// four-phase writer, counts requests that had to wait for queue space
	task automatic write_port(input int n);
		int waited;
		forever
		begin
			@(negedge CLK);
			if (wr_q[n].size() != 0)
			begin
				lc_msg_in[n] = wr_q[n].pop_front();
				lc_req_in[n] = 1'b1;
				waited = 0;
				@(negedge CLK);
				while (!lc_ack_out[n])
				begin
					waited++;
					@(negedge CLK);
				end
				if (waited > 0)
					write_stalls++;
				lc_req_in[n] = 1'b0;
				@(negedge CLK);
				while (lc_ack_out[n])
					@(negedge CLK);
			end
		end
	endtask

	task automatic read_port(input int n);
		ulpb_msg_t want;
		logic stall;
		forever
		begin
			@(negedge CLK);
			if (lc_req_out[n])
			begin
				if (exp_rx[n].size() == 0)
				begin
					errors++;
					$display("node %0d delivered a message nobody addressed to it", n);
				end
				else
				begin
					want = exp_rx[n].pop_front();
					stall = exp_stall[n].pop_front();
					if (stall)
						repeat (STALL_CYCLES) @(negedge CLK);
					check_msg($sformatf("lc_msg_out[%0d]", n), lc_msg_out[n], want);
					outstanding--;
				end
				lc_ack_in[n] = 1'b1;
				@(negedge CLK);
				while (lc_req_out[n])
					@(negedge CLK);
				lc_ack_in[n] = 1'b0;
			end
		end
	endtask

	task automatic result_port(input int n);
		logic want_ok;
		forever
		begin
			@(negedge CLK);
			if (tx_success[n] || tx_fail[n])
			begin
				if (exp_res[n].size() == 0)
				begin
					errors++;
					$display("node %0d raised a result flag with no frame pending", n);
				end
				else
				begin
					want_ok = exp_res[n].pop_front();
					check_flag($sformatf("tx_success[%0d]", n), tx_success[n], want_ok);
					check_flag($sformatf("tx_fail[%0d]", n), tx_fail[n], !want_ok);
					outstanding--;
				end
				tx_ack[n] = 1'b1;
				@(negedge CLK);
				while (tx_success[n] || tx_fail[n])
					@(negedge CLK);
				tx_ack[n] = 1'b0;
			end
		end
	endtask

	initial
	begin
		void'($urandom(SEED));
		RESET = 1'b0;
		lc_req_in = '0;
		lc_msg_in = '0;
		lc_ack_in = '0;
		tx_ack = '0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b1;
		for (int n = 0; n < NODE_COUNT; n++)
		begin
			automatic int k = n;
			fork
				write_port(k);
				read_port(k);
				result_port(k);
			join_none
		end
		@(posedge CLK);
		for (int i = 0; i < NUM_STIM; i++)
		begin
			queue_entry(STIM[i]);
			if (STIM[i].sync)
				wait_drain();
		end
		wait_drain();
		// one more ring round to catch stray deliveries
		repeat (NODE_COUNT * SLOT_CYCLES) @(posedge CLK);
		if (write_stalls == 0)
		begin
			errors++;
			$display("lc_ack_out never held off a write while the queue was full");
		end
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("timeout after %0d cycles with %0d items still outstanding",
			WATCHDOG_CYCLES, outstanding);
		$display("Checks failed");
		$finish;
	end

endmodule

/* sources.f */
rtl/ulpb_pkg.sv
rtl/ulpb_tx_fifo.sv
rtl/ulpb_tx_engine.sv
rtl/ulpb_rx_engine.sv
rtl/ulpb_node.sv
rtl/ulpb_ring_top.sv
dv/ulpb_ring_sva.sv
dv/ulpb_ring_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= ulpb_ring_tb
LOG ?= sim.log
SEED ?= 99858
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
FAIL_MSG := Checks failed

VFLAGS := --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
